//--- hdl/backend_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32E back end shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package backend_pkg;

    // data memory geometry
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_BLT  = 3'd3,
        BR_BGE  = 3'd4,
        BR_BLTU = 3'd5,
        BR_BGEU = 3'd6
    } br_op_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // same coding as the funct3 field of loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_size_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        alu_op_e     alu_op;
        br_op_e      br_op;
        mem_op_e     mem_op;
        mem_size_e   mem_size;
        logic        use_imm;
        logic [3:0]  rd;
        logic        rd_write;
        logic        is_break;
    } issue_t;

    typedef struct packed {
        logic [31:0] alu_result;
        logic [31:0] store_data;
        mem_op_e     mem_op;
        mem_size_e   mem_size;
        logic [3:0]  rd;
        logic        rd_write;
        logic        redirect_valid;
        logic [31:0] npc;
        logic        is_break;
    } exe_mem_t;

    typedef struct packed {
        logic [3:0]  rd;
        logic        rd_write;
        logic [31:0] wb_data;
        logic        is_break;
    } mem_wb_t;

    typedef struct packed {
        logic [31:0] npc;
    } redirect_t;

endpackage

//--- hdl/alu_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module alu_stage (
    input  backend_pkg::issue_t   issue_i,
    output backend_pkg::exe_mem_t exe_o
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] alu_res;
    logic        br_taken;

    assign op_a  = issue_i.rs1_data;
    assign op_b  = issue_i.use_imm ? issue_i.imm : issue_i.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (issue_i.alu_op)
            backend_pkg::ALU_ADD:    alu_res = op_a + op_b;
            backend_pkg::ALU_SUB:    alu_res = op_a - op_b;
            backend_pkg::ALU_AND:    alu_res = op_a & op_b;
            backend_pkg::ALU_OR:     alu_res = op_a | op_b;
            backend_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            backend_pkg::ALU_SLL:    alu_res = op_a << shamt;
            backend_pkg::ALU_SRL:    alu_res = op_a >> shamt;
            backend_pkg::ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
            backend_pkg::ALU_SLT:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            backend_pkg::ALU_SLTU:   alu_res = {31'd0, op_a < op_b};
            backend_pkg::ALU_PASS_B: alu_res = op_b;
            default:                 alu_res = 32'd0;
        endcase
    end

    // branch compare always uses both register operands
    always_comb begin
        case (issue_i.br_op)
            backend_pkg::BR_BEQ:  br_taken = issue_i.rs1_data == issue_i.rs2_data;
            backend_pkg::BR_BNE:  br_taken = issue_i.rs1_data != issue_i.rs2_data;
            backend_pkg::BR_BLT:
                br_taken = $signed(issue_i.rs1_data) < $signed(issue_i.rs2_data);
            backend_pkg::BR_BGE:
                br_taken = $signed(issue_i.rs1_data) >= $signed(issue_i.rs2_data);
            backend_pkg::BR_BLTU: br_taken = issue_i.rs1_data < issue_i.rs2_data;
            backend_pkg::BR_BGEU: br_taken = issue_i.rs1_data >= issue_i.rs2_data;
            default:              br_taken = 1'b0;
        endcase
    end

    always_comb begin
        exe_o = '0;
        // loads and stores take the address adder
        if (issue_i.mem_op != backend_pkg::MEM_NONE) begin
            exe_o.alu_result = issue_i.rs1_data + issue_i.imm;
        end else begin
            exe_o.alu_result = alu_res;
        end
        exe_o.store_data     = issue_i.rs2_data;
        exe_o.mem_op         = issue_i.mem_op;
        exe_o.mem_size       = issue_i.mem_size;
        exe_o.rd             = issue_i.rd;
        exe_o.rd_write       = issue_i.rd_write;
        exe_o.redirect_valid = br_taken;
        exe_o.npc            = issue_i.pc + issue_i.imm;
        exe_o.is_break       = issue_i.is_break;
    end

    // decode never emits a branch that also touches memory
    a_no_br_and_mem: assert property (@(issue_i)
        !(issue_i.br_op != backend_pkg::BR_NONE && issue_i.mem_op != backend_pkg::MEM_NONE));

endmodule

//--- hdl/stage_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Valid/ready pipeline register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush_i,

    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // accept when empty, or when the held item leaves this cycle
    // flush blocks any new entry
    assign in_ready_o  = !flush_i && (!valid_q || out_ready_i);
    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    // held item must not change until taken
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid_o && !out_ready_i |=> $stable(out_data_o));

endmodule

//--- hdl/mem_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory stage with local data RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_stage (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   exe_valid_i,
    output logic                   exe_ready_o,
    input  backend_pkg::exe_mem_t  exe_i,

    output logic                   wb_valid_o,
    input  logic                   wb_ready_i,
    output backend_pkg::mem_wb_t   wb_o,

    output logic                   redirect_valid_o,
    output backend_pkg::redirect_t redirect_o
);

    logic [31:0] dmem [backend_pkg::DMEM_WORDS];

    logic [backend_pkg::DMEM_AW-1:0] word_addr;
    logic [1:0]                      byte_off;
    logic                            xfer;
    logic [31:0]                     rdata;
    logic [31:0]                     lane;
    logic [31:0]                     load_data;
    logic [3:0]                      wr_be;
    logic [31:0]                     wr_data;
    logic                            redirect_valid_q;
    backend_pkg::redirect_t          redirect_q;

    assign word_addr = exe_i.alu_result[backend_pkg::DMEM_AW+1:2];
    assign byte_off  = exe_i.alu_result[1:0];

    // combinational stage, handshake passes straight through
    assign exe_ready_o = wb_ready_i;
    assign wb_valid_o  = exe_valid_i;
    assign xfer        = exe_valid_i && wb_ready_i;

    // store lanes, data replicated across the word
    always_comb begin
        case (exe_i.mem_size)
            backend_pkg::MEM_B, backend_pkg::MEM_BU: begin
                wr_be   = 4'b0001 << byte_off;
                wr_data = {4{exe_i.store_data[7:0]}};
            end
            backend_pkg::MEM_H, backend_pkg::MEM_HU: begin
                wr_be   = 4'b0011 << byte_off;
                wr_data = {2{exe_i.store_data[15:0]}};
            end
            default: begin
                wr_be   = 4'b1111;
                wr_data = exe_i.store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (xfer && exe_i.mem_op == backend_pkg::MEM_STORE) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_be[i]) begin
                    dmem[word_addr][i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

    assign rdata = dmem[word_addr];
    assign lane  = rdata >> {byte_off, 3'b000};

    always_comb begin
        case (exe_i.mem_size)
            backend_pkg::MEM_B:  load_data = {{24{lane[7]}}, lane[7:0]};
            backend_pkg::MEM_BU: load_data = {24'd0, lane[7:0]};
            backend_pkg::MEM_H:  load_data = {{16{lane[15]}}, lane[15:0]};
            backend_pkg::MEM_HU: load_data = {16'd0, lane[15:0]};
            default:             load_data = rdata;
        endcase
    end

    always_comb begin
        wb_o.rd       = exe_i.rd;
        wb_o.rd_write = exe_i.rd_write;
        wb_o.is_break = exe_i.is_break;
        if (exe_i.mem_op == backend_pkg::MEM_LOAD) begin
            wb_o.wb_data = load_data;
        end else begin
            wb_o.wb_data = exe_i.alu_result;
        end
    end

    // one-cycle strobe after the taken branch moves on
    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid_q <= 1'b0;
        end else begin
            redirect_valid_q <= xfer && exe_i.redirect_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer && exe_i.redirect_valid) begin
            redirect_q.npc <= exe_i.npc;
        end
    end

    assign redirect_valid_o = redirect_valid_q;
    assign redirect_o       = redirect_q;

    a_aligned: assert property (@(posedge clk) disable iff (reset)
        exe_valid_i && exe_i.mem_op != backend_pkg::MEM_NONE |->
            (exe_i.mem_size != backend_pkg::MEM_W || byte_off == 2'b00) &&
            (!(exe_i.mem_size inside {backend_pkg::MEM_H, backend_pkg::MEM_HU}) ||
             !byte_off[0]));

endmodule

//--- hdl/core_backend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32E pipeline back end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module core_backend (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush_i,

    input  logic                   issue_valid_i,
    output logic                   issue_ready_o,
    input  backend_pkg::issue_t    issue_i,

    output logic                   retire_valid_o,
    input  logic                   retire_ready_i,
    output backend_pkg::mem_wb_t   retire_o,

    output logic                   redirect_valid_o,
    output backend_pkg::redirect_t redirect_o
);

    backend_pkg::exe_mem_t exe_d;
    backend_pkg::exe_mem_t exe_q;
    logic                  exe_valid;
    logic                  exe_ready;

    backend_pkg::mem_wb_t  wb_d;
    logic                  wb_valid;
    logic                  wb_ready;

    alu_stage alu_stage_i (
        .issue_i (issue_i),
        .exe_o   (exe_d)
    );

    stage_reg #(
        .payload_t (backend_pkg::exe_mem_t)
    ) exe_mem_reg (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush_i),
        .in_valid_i  (issue_valid_i),
        .in_ready_o  (issue_ready_o),
        .in_data_i   (exe_d),
        .out_valid_o (exe_valid),
        .out_ready_i (exe_ready),
        .out_data_o  (exe_q)
    );

    mem_stage mem_stage_i (
        .clk              (clk),
        .reset            (reset),
        .exe_valid_i      (exe_valid),
        .exe_ready_o      (exe_ready),
        .exe_i            (exe_q),
        .wb_valid_o       (wb_valid),
        .wb_ready_i       (wb_ready),
        .wb_o             (wb_d),
        .redirect_valid_o (redirect_valid_o),
        .redirect_o       (redirect_o)
    );

    stage_reg #(
        .payload_t (backend_pkg::mem_wb_t)
    ) mem_wb_reg (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (flush_i),
        .in_valid_i  (wb_valid),
        .in_ready_o  (wb_ready),
        .in_data_i   (wb_d),
        .out_valid_o (retire_valid_o),
        .out_ready_i (retire_ready_i),
        .out_data_o  (retire_o)
    );

endmodule

//--- sim/tb_core_backend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Back end testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_core_backend;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk;
    logic                   reset;
    logic                   flush_i;
    logic                   issue_valid_i;
    logic                   issue_ready_o;
    backend_pkg::issue_t    issue_i;
    logic                   retire_valid_o;
    logic                   retire_ready_i;
    backend_pkg::mem_wb_t   retire_o;
    logic                   redirect_valid_o;
    backend_pkg::redirect_t redirect_o;

    integer seed = 51;
    int     bp_mode;
    logic   idle_mode;
    logic   saw_stall;

    // reference model state
    backend_pkg::issue_t  exp_q[$];
    logic [31:0]          redir_q[$];
    backend_pkg::mem_wb_t exp_head;
    int                   exp_count;
    logic [31:0]          redir_head;
    int                   redir_count;
    logic [31:0]          mmem [backend_pkg::DMEM_WORDS];

    backend_pkg::mem_size_e sizes [5] = '{backend_pkg::MEM_B, backend_pkg::MEM_H,
        backend_pkg::MEM_W, backend_pkg::MEM_BU, backend_pkg::MEM_HU};

    core_backend dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s at %0t", msg, $time);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] alu_ref(input backend_pkg::issue_t p);
        logic [31:0] a;
        logic [31:0] b;
        a = p.rs1_data;
        b = p.use_imm ? p.imm : p.rs2_data;
        case (p.alu_op)
            backend_pkg::ALU_ADD:  return a + b;
            backend_pkg::ALU_SUB:  return a - b;
            backend_pkg::ALU_AND:  return a & b;
            backend_pkg::ALU_OR:   return a | b;
            backend_pkg::ALU_XOR:  return a ^ b;
            backend_pkg::ALU_SLL:  return a << b[4:0];
            backend_pkg::ALU_SRL:  return a >> b[4:0];
            backend_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            backend_pkg::ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            backend_pkg::ALU_SLTU: return {31'd0, a < b};
            default:               return b;
        endcase
    endfunction

    function automatic logic branch_taken(input backend_pkg::issue_t p);
        logic [31:0] a;
        logic [31:0] b;
        a = p.rs1_data;
        b = p.rs2_data;
        case (p.br_op)
            backend_pkg::BR_BEQ:  return a == b;
            backend_pkg::BR_BNE:  return a != b;
            backend_pkg::BR_BLT:  return $signed(a) < $signed(b);
            backend_pkg::BR_BGE:  return $signed(a) >= $signed(b);
            backend_pkg::BR_BLTU: return a < b;
            backend_pkg::BR_BGEU: return a >= b;
            default:              return 1'b0;
        endcase
    endfunction

    function automatic backend_pkg::mem_wb_t expect_retire(input backend_pkg::issue_t p);
        backend_pkg::mem_wb_t r;
        logic [31:0] addr;
        logic [31:0] sh;
        addr = p.rs1_data + p.imm;
        sh = mmem[addr[backend_pkg::DMEM_AW+1:2]] >> {addr[1:0], 3'b000};
        r.rd = p.rd;
        r.rd_write = p.rd_write;
        r.is_break = p.is_break;
        if (p.mem_op == backend_pkg::MEM_LOAD) begin
            case (p.mem_size)
                backend_pkg::MEM_B:  r.wb_data = {{24{sh[7]}}, sh[7:0]};
                backend_pkg::MEM_BU: r.wb_data = {24'd0, sh[7:0]};
                backend_pkg::MEM_H:  r.wb_data = {{16{sh[15]}}, sh[15:0]};
                backend_pkg::MEM_HU: r.wb_data = {16'd0, sh[15:0]};
                default:             r.wb_data = sh;
            endcase
        end else if (p.mem_op == backend_pkg::MEM_STORE) begin
            r.wb_data = addr;
        end else begin
            r.wb_data = alu_ref(p);
        end
        return r;
    endfunction

    task automatic apply_store(input backend_pkg::issue_t p);
        logic [31:0] addr;
        logic [backend_pkg::DMEM_AW-1:0] w;
        addr = p.rs1_data + p.imm;
        w = addr[backend_pkg::DMEM_AW+1:2];
        if (p.mem_op == backend_pkg::MEM_STORE) begin
            if (p.mem_size == backend_pkg::MEM_B)
                mmem[w][addr[1:0]*8 +: 8] = p.rs2_data[7:0];
            else if (p.mem_size == backend_pkg::MEM_H)
                mmem[w][addr[1:0]*8 +: 16] = p.rs2_data[15:0];
            else
                mmem[w] = p.rs2_data;
        end
    endtask

    // kind 0 alu, 1 branch, 2 store, 3 load; memory kept to words 0..15
    function automatic backend_pkg::issue_t make_packet(input int kind);
        backend_pkg::issue_t p;
        int sz;
        p = '0;
        p.pc = $random(seed);
        p.imm = $random(seed);
        p.rs1_data = $random(seed);
        p.rs2_data = $random(seed);
        p.use_imm = 1'($random(seed));
        p.rd = 4'($random(seed));
        p.rd_write = 1'($random(seed));
        p.is_break = ($random(seed) & 15) == 0;
        p.mem_size = backend_pkg::MEM_W;
        p.alu_op = backend_pkg::alu_op_e'(4'($unsigned($random(seed)) % 11));
        if (kind == 1) begin
            p.br_op = backend_pkg::br_op_e'(3'(1 + $unsigned($random(seed)) % 6));
            if ($random(seed) & 1)
                p.rs2_data = p.rs1_data;
        end else if (kind >= 2) begin
            p.mem_op = (kind == 2) ? backend_pkg::MEM_STORE : backend_pkg::MEM_LOAD;
            sz = (kind == 2) ? $unsigned($random(seed)) % 3 : $unsigned($random(seed)) % 5;
            p.mem_size = sizes[sz];
            p.rs1_data = 32'(($unsigned($random(seed)) % 16) * 4);
            if (p.mem_size inside {backend_pkg::MEM_B, backend_pkg::MEM_BU})
                p.imm = 32'($unsigned($random(seed)) % 4);
            else if (p.mem_size inside {backend_pkg::MEM_H, backend_pkg::MEM_HU})
                p.imm = 32'(($random(seed) & 1) * 2);
            else
                p.imm = 32'd0;
        end
        return p;
    endfunction

    // returns on the edge that accepts the packet
    task automatic send(input backend_pkg::issue_t p);
        int n;
        n = 0;
        issue_valid_i <= 1'b1;
        issue_i <= p;
        do begin
            @(negedge clk);
            n++;
            if (n > 100)
                abort_run("timeout waiting for issue_ready_o");
        end while (!issue_ready_o);
        @(posedge clk);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        issue_valid_i <= 1'b0;
        do begin
            @(negedge clk);
            n++;
            if (n > 200)
                abort_run("timeout waiting for the pipeline to drain");
        end while (exp_q.size() != 0 || redir_q.size() != 0 || retire_valid_o);
        repeat (3) @(posedge clk);
    endtask

    // park an alu packet and then second in the two registers, then flush both
    task automatic flush_in_flight(input backend_pkg::issue_t second);
        bp_mode = 2;
        @(posedge clk);
        send(make_packet(0));
        send(second);
        issue_valid_i <= 1'b0;
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        bp_mode = 0;
    endtask

    always @(posedge clk) begin
        if (bp_mode == 0)
            retire_ready_i <= 1'b1;
        else if (bp_mode == 1)
            retire_ready_i <= ($random(seed) & 3) != 0;
        else
            retire_ready_i <= 1'b0;
    end

    // model queues follow the handshakes seen at each edge
    always @(posedge clk) begin
        if (reset || flush_i) begin
            exp_q.delete();
            redir_q.delete();
        end else begin
            if (issue_valid_i && !issue_ready_o)
                saw_stall = 1'b1;
            if (retire_valid_o && retire_ready_i && exp_q.size() > 0) begin
                apply_store(exp_q[0]);
                void'(exp_q.pop_front());
            end
            if (redirect_valid_o && redir_q.size() > 0)
                void'(redir_q.pop_front());
            if (issue_valid_i && issue_ready_o) begin
                exp_q.push_back(issue_i);
                if (branch_taken(issue_i))
                    redir_q.push_back(issue_i.pc + issue_i.imm);
            end
        end
        exp_count <= exp_q.size();
        exp_head <= (exp_q.size() > 0) ? expect_retire(exp_q[0]) : '0;
        redir_count <= redir_q.size();
        redir_head <= (redir_q.size() > 0) ? redir_q[0] : 32'd0;
    end

    a_reset_state: assert property (@(posedge clk)
        $fell(reset) |-> issue_ready_o && !retire_valid_o && !redirect_valid_o)
        else abort_run("outputs not at their idle values after reset");

    a_retire: assert property (@(posedge clk) disable iff (reset)
        retire_valid_o && retire_ready_i |-> exp_count != 0 && retire_o == exp_head)
        else report_mismatch("retire_o", {26'd0, exp_head}, {26'd0, retire_o});

    a_redirect: assert property (@(posedge clk) disable iff (reset)
        redirect_valid_o |-> redir_count != 0 && redirect_o.npc == redir_head)
        else report_mismatch("redirect_o", {32'd0, redir_head}, {32'd0, redirect_o.npc});

    a_hold: assert property (@(posedge clk) disable iff (reset)
        !flush_i && retire_valid_o && !retire_ready_i |=> retire_valid_o && $stable(retire_o))
        else abort_run("retire_o changed or dropped while stalled");

    a_latency: assert property (@(posedge clk) disable iff (reset)
        idle_mode && issue_valid_i && issue_ready_o |-> ##2 retire_valid_o)
        else abort_run("retire did not follow issue by 2 cycles");

    initial begin
        backend_pkg::issue_t p;
        for (int i = 0; i < backend_pkg::DMEM_WORDS; i++)
            mmem[i] = 32'd0;
        reset = 1'b1;
        flush_i = 1'b0;
        issue_valid_i = 1'b0;
        issue_i = '0;
        retire_ready_i = 1'b1;
        bp_mode = 0;
        idle_mode = 1'b1;
        saw_stall = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // fill words 0..15 so every later load reads defined data
        for (int w = 0; w < 16; w++) begin
            p = make_packet(2);
            p.mem_size = backend_pkg::MEM_W;
            p.rs1_data = 32'(w * 4);
            p.imm = 32'd0;
            send(p);
        end
        for (int i = 0; i < 12; i++) begin
            send(make_packet(i % 4));
            issue_valid_i <= 1'b0;
            repeat (i % 3) @(posedge clk);
        end
        wait_drain();

        idle_mode = 1'b0;
        bp_mode = 1;
        for (int i = 0; i < 300; i++)
            send(make_packet($unsigned($random(seed)) % 4));
        bp_mode = 0;
        wait_drain();

        // store held in the execute register, then flushed
        p = make_packet(2);
        p.mem_size = backend_pkg::MEM_W;
        p.rs1_data = 32'd12;
        p.imm = 32'd0;
        p.rs2_data = ~mmem[3];
        flush_in_flight(p);
        p = make_packet(3);
        p.mem_size = backend_pkg::MEM_W;
        p.rs1_data = 32'd12;
        p.imm = 32'd0;
        send(p);
        wait_drain();

        // taken branch flushed before it reaches the memory stage
        p = make_packet(1);
        p.br_op = backend_pkg::BR_BEQ;
        p.rs2_data = p.rs1_data;
        flush_in_flight(p);
        wait_drain();

        if (!saw_stall) begin
            abort_run("issue_ready_o never fell under back-pressure");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- core_backend.f
hdl/backend_pkg.sv
hdl/alu_stage.sv
hdl/stage_reg.sv
hdl/mem_stage.sv
hdl/core_backend.sv
sim/tb_core_backend.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f core_backend.f \
		--top-module tb_core_backend -Mdir obj_dir
	./obj_dir/Vtb_core_backend | tee /dev/stderr | grep "^TEST PASS$$"

clean:
	rm -rf obj_dir
